/* common/sdram_pkg.sv */
/*
 * Shared definitions for the SDRAM controller.
 * Holds the device geometry, the command and scheduler state encodings
 * and the timing values loaded into the control registers at reset.
 * Modules take what they need with a wildcard import in their header.
 */
`default_nettype none

package sdram_pkg;

	localparam int SDRAM_DEPTH = 23;	// byte address width, 8 MiB.
	localparam int COL_BITS    = 8;		// 256 columns.
	localparam int BANK_BITS   = 2;		// 4 banks.
	localparam int ROW_BITS    = 12;	// 4096 rows, also the address pin width.

	// opcode bits are {ras_n, cas_n, we_n}.
	typedef enum logic [2:0] {
		CMD_MRS   = 3'b000,
		CMD_REF   = 3'b001,
		CMD_PRE   = 3'b010,
		CMD_ACT   = 3'b011,
		CMD_WRITE = 3'b100,
		CMD_READ  = 3'b101,
		CMD_NOP   = 3'b111
	} sdram_cmd_e;

	typedef enum logic [3:0] {
		ST_IDLE,		// waiting for a request or a refresh.
		ST_ACT,			// opening the requested row.
		ST_WAIT_RCD,	// activate to read/write delay.
		ST_ISSUE,		// read or write once the data path allows it.
		ST_PRE,			// closing the wrong row on a miss.
		ST_WAIT_RP,		// precharge to activate delay.
		ST_PRE_ALL,		// closing every bank before refresh.
		ST_REFRESH,		// auto-refresh after tRP.
		ST_WAIT_RFC		// refresh cycle time.
	} sched_state_e;

	localparam logic [2:0]  DEF_TIM_RP   = 3'd2;
	localparam logic [2:0]  DEF_TIM_RCD  = 3'd2;
	localparam logic        DEF_TIM_CAS  = 1'b0;	// 0 is CL2, 1 is CL3.
	localparam logic [10:0] DEF_TIM_REFI = 11'd740;
	localparam logic [3:0]  DEF_TIM_RFC  = 4'd8;
	localparam logic [1:0]  DEF_TIM_WR   = 2'd1;

endpackage

`default_nettype wire

/* common/sdram_cmd_if.sv */
/*
 * One SDRAM command bundle as it goes to the pin registers.
 * The control registers and the scheduler each drive one instance
 * through the source modport; the top level picks one of them.
 */
`timescale 1ns/1ns
`default_nettype none

interface sdram_cmd_if import sdram_pkg::*; ();

	logic                 cs_n;	// high when the source is idle.
	sdram_cmd_e           cmd;	// CMD_NOP when idle.
	logic [ROW_BITS-1:0]  adr;
	logic [BANK_BITS-1:0] ba;

	modport source (output cs_n, output cmd, output adr, output ba);
	modport sink (input cs_n, input cmd, input adr, input ba);

endinterface

`default_nettype wire

/* common/sdram_sched_if.sv */
/*
 * Link between the command scheduler and the data-path sequencer.
 * The scheduler pulses read or write with a one-hot bank in the cycle
 * it drives the command; the sequencer answers with the safe flags
 * that gate the next read, write or precharge.
 */
`timescale 1ns/1ns
`default_nettype none

interface sdram_sched_if ();

	logic       read;				// one-cycle strobe.
	logic       write;				// one-cycle strobe.
	logic [3:0] bank;				// one-hot, valid with the strobes.
	logic       read_safe;
	logic       write_safe;			// low while read data is in flight.
	logic [3:0] precharge_safe;		// low during write recovery, per bank.

	modport sched (output read, output write, output bank,
		input read_safe, input write_safe, input precharge_safe);
	modport datapath (input read, input write, input bank,
		output read_safe, output write_safe, output precharge_safe);

endinterface

`default_nettype wire

/* design/sdram_csr.sv */
/*
 * Control registers written by software.
 * Holds bypass, soft reset and clock enable, the timing values used by
 * the scheduler and data path, and the one-cycle bypass command used
 * to run precharge-all, refresh and mode-register load by hand.
 */
`timescale 1ns/1ns
`default_nettype none

module sdram_csr import sdram_pkg::*; (
	input  logic        sys_clk,
	input  logic        rst_n,
	input  logic [2:0]  csr_a,
	input  logic        csr_we,
	input  logic [15:0] csr_di,
	output logic [15:0] csr_do,
	output logic        bypass,
	output logic        sdram_rst,
	output logic        cke,
	sdram_cmd_if.source cmd,
	output logic [2:0]  tim_rp,
	output logic [2:0]  tim_rcd,
	output logic        tim_cas,
	output logic [10:0] tim_refi,
	output logic [3:0]  tim_rfc,
	output logic [1:0]  tim_wr
);

	logic byp_cs_n;
	sdram_cmd_e byp_cmd;
	logic [11:0] byp_adr;
	logic [1:0] byp_ba;

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			bypass <= 1'b1;		// software owns the pins after reset.
			sdram_rst <= 1'b1;
			cke <= 1'b0;
			byp_cs_n <= 1'b1;
			byp_cmd <= CMD_NOP;
			byp_adr <= '0;
			byp_ba <= '0;
			tim_rp <= DEF_TIM_RP;
			tim_rcd <= DEF_TIM_RCD;
			tim_cas <= DEF_TIM_CAS;
			tim_refi <= DEF_TIM_REFI;
			tim_rfc <= DEF_TIM_RFC;
			tim_wr <= DEF_TIM_WR;
		end else begin
			byp_cs_n <= 1'b1;		// a command pulse lasts one cycle.
			byp_cmd <= CMD_NOP;
			if (csr_we) begin
				case (csr_a)
					3'd0: {cke, sdram_rst, bypass} <= csr_di[2:0];
					3'd1: begin
						byp_cs_n <= ~csr_di[0];
						byp_cmd <= sdram_cmd_e'(csr_di[3:1]);
					end
					3'd2: begin
						byp_adr <= csr_di[11:0];
						byp_ba <= csr_di[13:12];
					end
					3'd3: begin
						tim_rp <= csr_di[2:0];
						tim_rcd <= csr_di[5:3];
						tim_cas <= csr_di[6];
						tim_rfc <= csr_di[10:7];
						tim_wr <= csr_di[12:11];
					end
					3'd4: tim_refi <= csr_di[10:0];
					default: ;		// no register here.
				endcase
			end
		end
	end

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n)
			csr_do <= '0;
		else begin
			case (csr_a)
				3'd0: csr_do <= {13'd0, cke, sdram_rst, bypass};
				3'd2: csr_do <= {2'd0, byp_ba, byp_adr};
				3'd3: csr_do <= {3'd0, tim_wr, tim_rfc, tim_cas, tim_rcd, tim_rp};
				3'd4: csr_do <= {5'd0, tim_refi};
				default: csr_do <= '0;	// register 1 is write only.
			endcase
		end
	end

	assign cmd.cs_n = byp_cs_n;
	assign cmd.cmd = byp_cmd;
	assign cmd.adr = byp_adr;
	assign cmd.ba = byp_ba;

endmodule

`default_nettype wire

/* mgmt/sdram_sched.sv */
/*
 * Command scheduler.
 * Keeps one open row per bank, turns a bus request into ACTIVATE,
 * PRECHARGE, READ and WRITE commands with tRCD and tRP respected, and
 * runs periodic precharge-all plus auto-refresh. Commands leave this
 * block combinationally and are registered at the pins.
 */
`timescale 1ns/1ns
`default_nettype none

module sdram_sched import sdram_pkg::*; #(
	parameter int sdram_depth       = SDRAM_DEPTH,
	parameter int sdram_columndepth = COL_BITS
) (
	input  logic                   sys_clk,
	input  logic                   rst_n,
	input  logic                   sdram_rst,
	input  logic [2:0]             tim_rp,
	input  logic [2:0]             tim_rcd,
	input  logic [10:0]            tim_refi,
	input  logic [3:0]             tim_rfc,
	input  logic                   mgmt_stb,
	input  logic                   mgmt_we,
	input  logic [sdram_depth-2:0] mgmt_address,
	output logic                   mgmt_ack,
	sdram_sched_if.sched           sif,
	sdram_cmd_if.source            cmd
);

	sched_state_e state, state_nxt;
	logic [3:0] cnt;				// shared delay counter.
	logic cnt_load;
	logic [3:0] cnt_init;
	logic [10:0] refi_cnt;
	logic refresh_due;
	logic [3:0] bank_open;
	logic [ROW_BITS-1:0] open_row [4];
	logic [sdram_columndepth-1:0] col;
	logic [BANK_BITS-1:0] bank;
	logic [ROW_BITS-1:0] row;
	logic access_ok;
	logic issue;
	logic cs_n_c;
	sdram_cmd_e cmd_c;
	logic [ROW_BITS-1:0] adr_c;

	// column 7:0, bank 9:8, row 21:10 of the word address.
	assign col = mgmt_address[sdram_columndepth-1:0];
	assign bank = mgmt_address[sdram_columndepth +: BANK_BITS];
	assign row = mgmt_address[sdram_columndepth+BANK_BITS +: ROW_BITS];
	assign access_ok = mgmt_we ? sif.write_safe : sif.read_safe;

	always_comb begin
		state_nxt = state;
		cs_n_c = 1'b1;
		cmd_c = CMD_NOP;
		adr_c = '0;
		issue = 1'b0;
		cnt_load = 1'b0;
		cnt_init = '0;
		case (state)
			ST_IDLE: if (!sdram_rst) begin
				if (refresh_due)
					state_nxt = ST_PRE_ALL;		// refresh wins over the bus.
				else if (mgmt_stb) begin
					if (!bank_open[bank])
						state_nxt = ST_ACT;
					else if (open_row[bank] != row)
						state_nxt = ST_PRE;		// row miss.
					else
						issue = access_ok;		// row hit, no extra state.
				end
			end
			ST_ACT: begin
				cs_n_c = 1'b0;
				cmd_c = CMD_ACT;
				adr_c = row;
				cnt_load = 1'b1;
				cnt_init = {1'b0, tim_rcd};
				state_nxt = ST_WAIT_RCD;
			end
			ST_WAIT_RCD: if (cnt == 4'd0) state_nxt = ST_ISSUE;
			ST_ISSUE: issue = access_ok;
			ST_PRE: if (sif.precharge_safe[bank]) begin
				cs_n_c = 1'b0;
				cmd_c = CMD_PRE;		// a10 low, this bank only.
				cnt_load = 1'b1;
				cnt_init = {1'b0, tim_rp};
				state_nxt = ST_WAIT_RP;
			end
			ST_WAIT_RP: if (cnt == 4'd0) state_nxt = ST_ACT;
			ST_PRE_ALL: if (&sif.precharge_safe) begin
				cs_n_c = 1'b0;
				cmd_c = CMD_PRE;
				adr_c[10] = 1'b1;		// all banks.
				cnt_load = 1'b1;
				cnt_init = {1'b0, tim_rp};
				state_nxt = ST_REFRESH;
			end
			ST_REFRESH: if (cnt == 4'd0) begin
				cs_n_c = 1'b0;
				cmd_c = CMD_REF;
				cnt_load = 1'b1;
				cnt_init = tim_rfc;
				state_nxt = ST_WAIT_RFC;
			end
			ST_WAIT_RFC: if (cnt == 4'd0) state_nxt = ST_IDLE;
			default: state_nxt = ST_IDLE;
		endcase
		if (issue) begin
			cs_n_c = 1'b0;
			cmd_c = mgmt_we ? CMD_WRITE : CMD_READ;
			adr_c = {{(ROW_BITS-sdram_columndepth){1'b0}}, col};	// a10 low, no auto precharge.
			state_nxt = ST_IDLE;
		end
	end

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			cnt <= '0;
		end else if (sdram_rst) begin
			state <= ST_IDLE;
			cnt <= '0;
		end else begin
			state <= state_nxt;
			if (cnt_load)
				cnt <= cnt_init;
			else if (cnt != 4'd0)
				cnt <= cnt - 4'd1;
		end
	end

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			bank_open <= '0;
			refi_cnt <= '0;
			refresh_due <= 1'b0;
		end else if (sdram_rst) begin
			bank_open <= '0;
			refi_cnt <= tim_refi;
			refresh_due <= 1'b0;
		end else begin
			if (cmd_c == CMD_REF)
				refresh_due <= 1'b0;
			if (refi_cnt == 11'd0) begin
				refi_cnt <= tim_refi;
				refresh_due <= 1'b1;
			end else
				refi_cnt <= refi_cnt - 11'd1;
			if (cmd_c == CMD_ACT)
				bank_open[bank] <= 1'b1;
			if (cmd_c == CMD_PRE && !adr_c[10])
				bank_open[bank] <= 1'b0;
			if (state == ST_WAIT_RFC && cnt == 4'd0)
				bank_open <= '0;		// closed by the precharge-all.
		end
	end

	always_ff @(posedge sys_clk) begin
		if (cmd_c == CMD_ACT)
			open_row[bank] <= row;
	end

	assign mgmt_ack = issue;
	assign sif.read = issue & ~mgmt_we;
	assign sif.write = issue & mgmt_we;
	assign sif.bank = 4'b0001 << bank;
	assign cmd.cs_n = cs_n_c;
	assign cmd.cmd = cmd_c;
	assign cmd.adr = adr_c;
	assign cmd.ba = bank;

endmodule

`default_nettype wire

/* design/sdram_busif.sv */
/*
 * Bus front end.
 * Turns a held fml_stb into exactly one scheduler request and gives
 * the bus its acknowledge when the data path has finished the access.
 */
`timescale 1ns/1ns
`default_nettype none

module sdram_busif import sdram_pkg::*; #(
	parameter int sdram_depth = SDRAM_DEPTH
) (
	input  logic                   sys_clk,
	input  logic                   rst_n,
	input  logic                   sdram_rst,
	input  logic [sdram_depth-1:0] fml_adr,
	input  logic                   fml_stb,
	input  logic                   fml_we,
	output logic                   fml_ack,
	output logic                   mgmt_stb,
	output logic                   mgmt_we,
	output logic [sdram_depth-2:0] mgmt_address,
	input  logic                   mgmt_ack,
	input  logic                   data_ack
);

	logic pending;		// command issued, data not yet done.

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n)
			pending <= 1'b0;
		else if (sdram_rst)
			pending <= 1'b0;
		else if (mgmt_ack)
			pending <= 1'b1;
		else if (data_ack)
			pending <= 1'b0;
	end

	assign mgmt_stb = fml_stb & ~pending;
	assign mgmt_we = fml_we;
	assign mgmt_address = fml_adr[sdram_depth-1:1];	// drop the byte bit.
	assign fml_ack = data_ack;

endmodule

`default_nettype wire

/* design/sdram_datactl.sv */
/*
 * Data-path sequencer.
 * Follows each read through the CAS latency and each write through
 * write recovery, raises the safe flags for the scheduler, steers the
 * DQ direction and pulses data_ack when the bus data is done.
 */
`timescale 1ns/1ns
`default_nettype none

module sdram_datactl (
	input  logic            sys_clk,
	input  logic            rst_n,
	input  logic            sdram_rst,
	sdram_sched_if.datapath sif,
	input  logic            tim_cas,
	input  logic [1:0]      tim_wr,
	output logic            data_ack,
	output logic            direction,
	output logic            direction_r
);

	logic [4:0] rd_sr;			// read strobe delayed by 1 to 5 cycles.
	logic wr_ack;
	logic [2:0] wr_cnt [4];		// write recovery left, per bank.
	logic [3:0] pre_ok;

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_sr <= '0;
			wr_ack <= 1'b0;
			direction_r <= 1'b0;
			wr_cnt <= '{default: '0};
		end else if (sdram_rst) begin
			rd_sr <= '0;
			wr_ack <= 1'b0;
			direction_r <= 1'b0;
			wr_cnt <= '{default: '0};
		end else begin
			rd_sr <= {rd_sr[3:0], sif.read};
			wr_ack <= sif.write;
			direction_r <= direction;	// drives dq with the write on the pins.
			for (int i = 0; i < 4; i++) begin
				if (sif.write && sif.bank[i])
					wr_cnt[i] <= {1'b0, tim_wr} + 3'd1;
				else if (wr_cnt[i] != 3'd0)
					wr_cnt[i] <= wr_cnt[i] - 3'd1;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < 4; i++)
			pre_ok[i] = (wr_cnt[i] == 3'd0);
	end

	// read data lands in the dq input register cl+2 cycles after the strobe.
	assign data_ack = wr_ack | (tim_cas ? rd_sr[4] : rd_sr[3]);
	assign sif.write_safe = tim_cas ? ~|rd_sr[4:0] : ~|rd_sr[3:0];
	assign sif.read_safe = ~wr_ack;		// write data cycle still on dq.
	assign sif.precharge_safe = pre_ok;
	assign direction = sif.write;

endmodule

`default_nettype wire

/* design/sdram_dqio.sv */
/*
 * DQ and DQM pin registers.
 * Write data and mask are loaded with the write strobe and driven one
 * cycle later; DQ is sampled into rdata on every clock.
 */
`timescale 1ns/1ns
`default_nettype none

module sdram_dqio (
	input  logic        sys_clk,
	input  logic        rst_n,
	input  logic        direction,
	input  logic        direction_r,
	input  logic [1:0]  mask,
	input  logic [15:0] wdata,
	output logic [15:0] rdata,
	output logic [1:0]  sdram_dqm,
	inout  wire  [15:0] sdram_dq
);

	logic [15:0] dq_out;

	always_ff @(posedge sys_clk) begin
		if (direction)
			dq_out <= wdata;
		rdata <= sdram_dq;		// input register, valid after cl.
	end

	// reads keep every byte enabled.
	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n)
			sdram_dqm <= 2'b00;
		else
			sdram_dqm <= direction ? mask : 2'b00;
	end

	assign sdram_dq = direction_r ? dq_out : 16'hzzzz;

endmodule

`default_nettype wire

/* design/sdram_ctl.sv */
/*
 * SDRAM controller top level for one x16 SDR device.
 * Picks the bypass command from the control registers or the scheduler
 * command, registers every control pin so it can sit in an I/O
 * flip-flop, and connects the bus front end, scheduler and data path.
 */
`timescale 1ns/1ns
`default_nettype none

module sdram_ctl import sdram_pkg::*; #(
	parameter int sdram_depth       = SDRAM_DEPTH,	// byte address width.
	parameter int sdram_columndepth = COL_BITS
) (
	input  logic                   sys_clk,
	input  logic                   rst_n,
	input  logic [2:0]             csr_a,
	input  logic                   csr_we,
	input  logic [15:0]            csr_di,
	output logic [15:0]            csr_do,
	input  logic [sdram_depth-1:0] fml_adr,
	input  logic                   fml_stb,
	input  logic                   fml_we,
	output logic                   fml_ack,
	input  logic [1:0]             fml_sel,
	input  logic [15:0]            fml_di,
	output logic [15:0]            fml_do,
	output logic                   sdram_cke,
	output logic                   sdram_cs_n,
	output logic                   sdram_ras_n,
	output logic                   sdram_cas_n,
	output logic                   sdram_we_n,
	output logic [11:0]            sdram_adr,
	output logic [1:0]             sdram_ba,
	output logic [1:0]             sdram_dqm,
	inout  wire  [15:0]            sdram_dq
);

	logic bypass;
	logic sdram_rst;
	logic cke;
	logic [2:0] tim_rp;
	logic [2:0] tim_rcd;
	logic tim_cas;
	logic [10:0] tim_refi;
	logic [3:0] tim_rfc;
	logic [1:0] tim_wr;
	logic mgmt_stb;
	logic mgmt_we;
	logic [sdram_depth-2:0] mgmt_address;	// word address.
	logic mgmt_ack;
	logic data_ack;
	logic direction;
	logic direction_r;
	logic sel_cs_n;
	sdram_cmd_e sel_cmd;
	logic [11:0] sel_adr;
	logic [1:0] sel_ba;

	sdram_cmd_if byp_cmd ();		// software command.
	sdram_cmd_if sch_cmd ();		// scheduler command.
	sdram_sched_if sched_bus ();

	// bypass hands the pins to software for the power-up sequence.
	assign sel_cs_n = bypass ? byp_cmd.cs_n : sch_cmd.cs_n;
	assign sel_cmd  = bypass ? byp_cmd.cmd  : sch_cmd.cmd;
	assign sel_adr  = bypass ? byp_cmd.adr  : sch_cmd.adr;
	assign sel_ba   = bypass ? byp_cmd.ba   : sch_cmd.ba;

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			sdram_cke <= 1'b0;
			sdram_cs_n <= 1'b1;		// deselected until enabled.
			{sdram_ras_n, sdram_cas_n, sdram_we_n} <= CMD_NOP;
		end else begin
			sdram_cke <= cke;
			sdram_cs_n <= sel_cs_n;
			{sdram_ras_n, sdram_cas_n, sdram_we_n} <= sel_cmd;
		end
	end

	always_ff @(posedge sys_clk) begin
		sdram_adr <= sel_adr;
		sdram_ba <= sel_ba;
	end

	sdram_csr csr_i (.sys_clk, .rst_n, .csr_a, .csr_we, .csr_di, .csr_do,
		.bypass, .sdram_rst, .cke, .cmd(byp_cmd.source),
		.tim_rp, .tim_rcd, .tim_cas, .tim_refi, .tim_rfc, .tim_wr);

	sdram_sched #(.sdram_depth(sdram_depth), .sdram_columndepth(sdram_columndepth)) sched_i (
		.sys_clk, .rst_n, .sdram_rst, .tim_rp, .tim_rcd, .tim_refi, .tim_rfc,
		.mgmt_stb, .mgmt_we, .mgmt_address, .mgmt_ack,
		.sif(sched_bus.sched), .cmd(sch_cmd.source));

	sdram_busif #(.sdram_depth(sdram_depth)) busif_i (.sys_clk, .rst_n, .sdram_rst,
		.fml_adr, .fml_stb, .fml_we, .fml_ack,
		.mgmt_stb, .mgmt_we, .mgmt_address, .mgmt_ack, .data_ack);

	sdram_datactl datactl_i (.sys_clk, .rst_n, .sdram_rst, .sif(sched_bus.datapath),
		.tim_cas, .tim_wr, .data_ack, .direction, .direction_r);

	// fml_sel enables a byte, dqm masks it.
	sdram_dqio dqio_i (.sys_clk, .rst_n, .direction, .direction_r, .mask(~fml_sel),
		.wdata(fml_di), .rdata(fml_do), .sdram_dqm, .sdram_dq);

endmodule

`default_nettype wire

/* tests/sdram_ctl_checker.sv */
/*
 * Protocol assertions for the SDRAM controller.
 * Bound into every sdram_ctl instance; checks the bus acknowledge,
 * quiet pins during soft reset and the data-path safe flags.
 */
`timescale 1ns/1ns
`default_nettype none

module sdram_ctl_checker import sdram_pkg::*; (
	input logic         sys_clk,
	input logic         rst_n,
	input logic         fml_stb,
	input logic         fml_ack,
	input logic         bypass,
	input logic         sdram_rst,
	input logic         sdram_cs_n,
	input logic         sdram_ras_n,
	input logic         sdram_cas_n,
	input logic         sdram_we_n,
	input logic         read_safe,
	input logic         write_safe,
	input sched_state_e sched_state
);

	sdram_cmd_e pin_op;
	logic pins_nop;

	assign pin_op = sdram_cmd_e'({sdram_ras_n, sdram_cas_n, sdram_we_n});
	assign pins_nop = sdram_cs_n || (pin_op == CMD_NOP);

	ack_pulse: assert property (@(posedge sys_clk) disable iff (!rst_n)
		fml_ack |=> !fml_ack) else $error("fml_ack longer than one cycle");

	ack_with_stb: assert property (@(posedge sys_clk) disable iff (!rst_n)
		fml_ack |-> fml_stb) else $error("fml_ack without fml_stb");

	// an idle scheduler in soft reset leaves only NOP for the pin register.
	rst_quiet: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(sdram_rst && !bypass && sched_state == ST_IDLE) |=> pins_nop)
		else $error("command on the pins during soft reset");

	// the pins show a command one cycle after the safe flag allowed it.
	read_gate: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(!sdram_cs_n && pin_op == CMD_READ && !$past(bypass)) |-> $past(read_safe))
		else $error("READ issued while not read safe");

	write_gate: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(!sdram_cs_n && pin_op == CMD_WRITE && !$past(bypass)) |-> $past(write_safe))
		else $error("WRITE issued while not write safe");

endmodule

bind sdram_ctl sdram_ctl_checker checker_i (
	.sys_clk, .rst_n, .fml_stb, .fml_ack, .bypass, .sdram_rst,
	.sdram_cs_n, .sdram_ras_n, .sdram_cas_n, .sdram_we_n,
	.read_safe(sched_bus.read_safe), .write_safe(sched_bus.write_safe),
	.sched_state(sched_i.state)
);

`default_nettype wire

/* tests/sdram_ctl_tb.sv */
/*
 * Directed testbench for the SDRAM controller.
 * Holds a behavioral x16 SDRAM model on the pins, runs the power-up
 * sequence through bypass and then checks data, row handling, bank
 * interleave and refresh through the bus port. Run from the file list.
 */
`timescale 1ns/1ns
`default_nettype none

module sdram_ctl_tb import sdram_pkg::*; ();

	localparam int cas_lat = 2;		// programmed through the mode register.

	logic sys_clk;
	logic rst_n;
	logic [2:0] csr_a;
	logic csr_we;
	logic [15:0] csr_di;
	logic [15:0] csr_do;
	logic [SDRAM_DEPTH-1:0] fml_adr;
	logic fml_stb;
	logic fml_we;
	logic fml_ack;
	logic [1:0] fml_sel;
	logic [15:0] fml_di;
	logic [15:0] fml_do;
	logic sdram_cke;
	logic sdram_cs_n;
	logic sdram_ras_n;
	logic sdram_cas_n;
	logic sdram_we_n;
	logic [11:0] sdram_adr;
	logic [1:0] sdram_ba;
	logic [1:0] sdram_dqm;
	wire [15:0] sdram_dq;

	int value_errs = 0;
	int cmd_errs = 0;
	int proto_errs = 0;
	logic [31:0] lcg_state = 32'hcf40;
	logic [15:0] exp_mem [int];		// expected words by word address.
	logic [21:0] used_adr [$];

	// sdram model state.
	logic [3:0] mdl_open = '0;
	logic [11:0] mdl_row [4];
	logic [15:0] mdl_mem [int];
	int mdl_cl = 0;		// no latency until the mode register is loaded.
	logic [2:0] pipe_v = '0;	// read data, one stage per cycle after READ.
	logic [15:0] pipe_d [3];
	sdram_cmd_e mdl_cmd;
	int mdl_key;
	logic [15:0] mdl_word;
	sdram_cmd_e log_cmd [$];	// every command the model accepted.
	logic [11:0] log_adr [$];

	sdram_ctl sdram_ctl_i (.sys_clk, .rst_n, .csr_a, .csr_we, .csr_di, .csr_do,
		.fml_adr, .fml_stb, .fml_we, .fml_ack, .fml_sel, .fml_di, .fml_do,
		.sdram_cke, .sdram_cs_n, .sdram_ras_n, .sdram_cas_n, .sdram_we_n,
		.sdram_adr, .sdram_ba, .sdram_dqm, .sdram_dq);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	// data is valid at the edge cl cycles after the READ edge.
	assign sdram_dq = (mdl_cl == 3) ? (pipe_v[2] ? pipe_d[2] : 16'hzzzz)
		: (pipe_v[1] ? pipe_d[1] : 16'hzzzz);

	always @(posedge sys_clk) begin
		pipe_v <= {pipe_v[1:0], 1'b0};
		pipe_d[1] <= pipe_d[0];
		pipe_d[2] <= pipe_d[1];
		mdl_cmd = sdram_cmd_e'({sdram_ras_n, sdram_cas_n, sdram_we_n});
		if (sdram_cke && !sdram_cs_n && mdl_cmd != CMD_NOP) begin
			log_cmd.push_back(mdl_cmd);
			log_adr.push_back(sdram_adr);
			mdl_key = {sdram_ba, mdl_row[sdram_ba], sdram_adr[7:0]};
			if ((mdl_cmd == CMD_READ || mdl_cmd == CMD_WRITE) && !mdl_open[sdram_ba]) begin
				$display("model: %s to closed bank %0d", mdl_cmd.name(), sdram_ba);
				proto_errs++;
			end
			case (mdl_cmd)
				CMD_ACT: begin
					if (mdl_open[sdram_ba]) begin
						$display("model: ACTIVATE to open bank %0d", sdram_ba);
						proto_errs++;
					end
					mdl_open[sdram_ba] = 1'b1;
					mdl_row[sdram_ba] = sdram_adr;
				end
				CMD_PRE: begin
					if (sdram_adr[10])
						mdl_open = '0;		// precharge all.
					else
						mdl_open[sdram_ba] = 1'b0;
				end
				CMD_REF: begin
					if (mdl_open != '0) begin
						$display("model: REFRESH with a bank still open");
						proto_errs++;
					end
				end
				CMD_MRS: mdl_cl = sdram_adr[6:4];
				CMD_WRITE: begin
					mdl_word = mdl_mem.exists(mdl_key) ? mdl_mem[mdl_key] : 16'hxxxx;
					if (!sdram_dqm[0])
						mdl_word[7:0] = sdram_dq[7:0];
					if (!sdram_dqm[1])
						mdl_word[15:8] = sdram_dq[15:8];
					mdl_mem[mdl_key] = mdl_word;
				end
				CMD_READ: begin
					pipe_v[0] <= 1'b1;
					pipe_d[0] <= mdl_mem.exists(mdl_key) ? mdl_mem[mdl_key] : 16'hxxxx;
				end
				default: ;
			endcase
		end
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic sdram_cmd_e pin_cmd();
		if (sdram_cs_n)
			return CMD_NOP;		// deselect acts as NOP.
		return sdram_cmd_e'({sdram_ras_n, sdram_cas_n, sdram_we_n});
	endfunction

	// register 3 layout: rp 2:0, rcd 5:3, cas 6, rfc 10:7, wr 12:11.
	function automatic logic [15:0] tim_word(input logic [2:0] rp, input logic [2:0] rcd,
			input logic cas, input logic [3:0] rfc, input logic [1:0] wr);
		return {3'd0, wr, rfc, cas, rcd, rp};
	endfunction

	function automatic logic [21:0] word_adr(input logic [1:0] ba, input logic [11:0] row,
			input logic [7:0] col);
		return {row, ba, col};
	endfunction

	function automatic logic [15:0] merge_bytes(input logic [15:0] old, input logic [15:0] data,
			input logic [1:0] sel);
		return {sel[1] ? data[15:8] : old[15:8], sel[0] ? data[7:0] : old[7:0]};
	endfunction

	task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (act !== exp) begin
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
			value_errs++;
		end
	endtask

	task automatic check_cmd(input string name, input sdram_cmd_e exp, input sdram_cmd_e act);
		if (act !== exp) begin
			$display("FAIL %s: expected %s, actual %s (%b)", name, exp.name(), act.name(), act);
			cmd_errs++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("FAIL %s: expected %0d, actual %0d", name, exp, act);
			value_errs++;
		end
	endtask

	task automatic clear_log();
		log_cmd.delete();
		log_adr.delete();
	endtask

	task automatic csr_write(input logic [2:0] a, input logic [15:0] d);
		@(negedge sys_clk);
		csr_a = a;
		csr_di = d;
		csr_we = 1'b1;
		@(negedge sys_clk);
		csr_we = 1'b0;
	endtask

	task automatic csr_read(input logic [2:0] a, output logic [15:0] d);
		@(negedge sys_clk);
		csr_a = a;
		@(negedge sys_clk);
		d = csr_do;		// registered read, one cycle behind csr_a.
	endtask

	// holds the strobe through the ack cycle; lat counts READ on the pins to ack.
	task automatic fml_access(input string name, input logic we, input logic [21:0] wadr,
			input logic [1:0] sel, input logic [15:0] wdat,
			output logic [15:0] rdat, output int lat);
		int rd_at;
		bit done;
		rdat = '0;
		lat = -1;
		rd_at = -1;
		done = 1'b0;
		@(negedge sys_clk);
		fml_adr = {wadr, 1'b0};
		fml_we = we;
		fml_sel = sel;
		fml_di = wdat;
		fml_stb = 1'b1;
		for (int t = 0; t < 64 && !done; t++) begin
			@(negedge sys_clk);
			if (pin_cmd() == CMD_READ)
				rd_at = t;
			if (fml_ack) begin
				done = 1'b1;
				rdat = fml_do;
				lat = t - rd_at;
			end
		end
		if (!done) begin
			$display("%s: no fml_ack within 64 cycles", name);
			proto_errs++;
		end
		@(negedge sys_clk);
		fml_stb = 1'b0;
	endtask

	// one software command: nop, command for one cycle, nop again.
	task automatic bypass_cmd(input string name, input sdram_cmd_e op, input logic [11:0] adr,
			input logic [1:0] ba);
		csr_write(3'd2, {2'b00, ba, adr});
		clear_log();
		csr_write(3'd1, {12'd0, op, 1'b1});
		check_cmd(name, CMD_NOP, pin_cmd());
		@(negedge sys_clk);
		check_cmd(name, op, pin_cmd());
		check_word(name, {2'b00, ba, adr}, {2'b00, sdram_ba, sdram_adr});
		@(negedge sys_clk);
		check_cmd(name, CMD_NOP, pin_cmd());
		check_count({name, " received"}, 1, log_cmd.size());
		if (log_cmd.size() > 0)
			check_cmd({name, " received"}, op, log_cmd[0]);
	endtask

	task automatic test_csr_regs();
		logic [15:0] v;
		logic [15:0] t;
		csr_read(3'd0, v);
		check_word("csr reset reg0", 16'h0003, v);	// bypass and soft reset, cke low.
		csr_read(3'd3, v);
		check_word("csr reset reg3",
			tim_word(DEF_TIM_RP, DEF_TIM_RCD, DEF_TIM_CAS, DEF_TIM_RFC, DEF_TIM_WR), v);
		csr_read(3'd4, v);
		check_word("csr reset reg4", {5'd0, DEF_TIM_REFI}, v);
		t = tim_word(3'd3, 3'd4, 1'b1, 4'd11, 2'd2);
		csr_write(3'd3, t);
		csr_read(3'd3, v);
		check_word("csr timing reg3", t, v);
		csr_write(3'd4, 16'd1234);
		csr_read(3'd4, v);
		check_word("csr timing reg4", 16'd1234, v);
		csr_read(3'd5, v);
		check_word("csr unused reg5", 16'h0000, v);
		csr_write(3'd3, tim_word(DEF_TIM_RP, DEF_TIM_RCD, DEF_TIM_CAS, DEF_TIM_RFC, DEF_TIM_WR));
		csr_write(3'd4, {5'd0, DEF_TIM_REFI});
	endtask

	task automatic test_bypass_init();
		csr_write(3'd0, 16'h0007);		// cke on, still bypass and soft reset.
		bypass_cmd("bypass precharge all", CMD_PRE, 12'h400, 2'd0);
		bypass_cmd("bypass refresh 1", CMD_REF, 12'h000, 2'd0);
		bypass_cmd("bypass refresh 2", CMD_REF, 12'h000, 2'd0);
		bypass_cmd("bypass mode register", CMD_MRS, {5'd0, 3'(cas_lat), 4'd0}, 2'd0);	// bl1.
		check_count("model cas latency", cas_lat, mdl_cl);
	endtask

	task automatic test_write_read();
		logic [31:0] r;
		logic [21:0] wa;
		logic [15:0] rd;
		logic [1:0] sel;
		int lat;
		used_adr.delete();
		for (int i = 0; i < 6; i++) begin
			r = next_rand();
			wa = r[21:0];
			r = next_rand();
			fml_access("full write", 1'b1, wa, 2'b11, r[15:0], rd, lat);
			exp_mem[wa] = r[15:0];
			used_adr.push_back(wa);
		end
		foreach (used_adr[i]) begin
			r = next_rand();
			sel = r[0] ? 2'b01 : 2'b10;		// one byte only.
			fml_access("partial write", 1'b1, used_adr[i], sel, r[31:16], rd, lat);
			exp_mem[used_adr[i]] = merge_bytes(exp_mem[used_adr[i]], r[31:16], sel);
		end
		foreach (used_adr[i]) begin
			fml_access("read back", 1'b0, used_adr[i], 2'b11, 16'h0000, rd, lat);
			check_word("write read data", exp_mem[used_adr[i]], rd);
			check_count("read ack latency", cas_lat + 1, lat);	// strobe is a cycle before the pins.
		end
	endtask

	task automatic test_refresh();
		bit seen_pre;
		bit seen_ref;
		int limit;
		logic [15:0] rd;
		int lat;
		seen_pre = 1'b0;
		seen_ref = 1'b0;
		limit = DEF_TIM_REFI + 20;
		for (int t = 0; t < limit && !seen_ref; t++) begin
			@(negedge sys_clk);
			if (pin_cmd() == CMD_PRE && sdram_adr[10])
				seen_pre = 1'b1;
			if (pin_cmd() == CMD_REF && seen_pre)
				seen_ref = 1'b1;
		end
		if (!seen_ref) begin
			$display("refresh: no precharge-all and REFRESH within %0d cycles", limit);
			proto_errs++;
		end
		foreach (used_adr[i]) begin
			fml_access("refresh read", 1'b0, used_adr[i], 2'b11, 16'h0000, rd, lat);
			check_word("data after refresh", exp_mem[used_adr[i]], rd);
		end
	endtask

	task automatic test_row_miss();
		logic [31:0] r;
		logic [21:0] a_old;
		logic [21:0] a_new;
		logic [15:0] rd;
		int lat;
		r = next_rand();
		a_old = word_adr(2'd1, 12'd5, r[7:0]);
		a_new = word_adr(2'd1, 12'd9, r[15:8]);
		fml_access("row miss open", 1'b1, a_old, 2'b11, r[31:16], rd, lat);
		exp_mem[a_old] = r[31:16];
		r = next_rand();
		clear_log();
		fml_access("row miss write", 1'b1, a_new, 2'b11, r[15:0], rd, lat);
		exp_mem[a_new] = r[15:0];
		check_count("row miss commands", 3, log_cmd.size());
		if (log_cmd.size() == 3) begin
			check_cmd("row miss first", CMD_PRE, log_cmd[0]);
			check_word("row miss precharge a10", 16'h0000, {15'd0, log_adr[0][10]});
			check_cmd("row miss second", CMD_ACT, log_cmd[1]);
			check_word("row miss activate row", 16'd9, {4'd0, log_adr[1]});
			check_cmd("row miss third", CMD_WRITE, log_cmd[2]);
		end
		fml_access("row miss read old", 1'b0, a_old, 2'b11, 16'h0000, rd, lat);
		check_word("row miss old data", exp_mem[a_old], rd);
		fml_access("row miss read new", 1'b0, a_new, 2'b11, 16'h0000, rd, lat);
		check_word("row miss new data", exp_mem[a_new], rd);
	endtask

	task automatic test_bank_spread();
		logic [31:0] r;
		logic [21:0] wa;
		logic [15:0] rd;
		int lat;
		int pre_cnt;
		for (int b = 0; b < 4; b++) begin
			r = next_rand();
			wa = word_adr(2'(b), 12'd7, r[7:0]);
			fml_access("bank write", 1'b1, wa, 2'b11, r[31:16], rd, lat);
			exp_mem[wa] = r[31:16];
			used_adr.push_back(wa);
		end
		clear_log();		// row 7 now open in every bank.
		for (int b = 3; b >= 0; b--) begin
			wa = used_adr[used_adr.size() - 4 + b];
			fml_access("bank read", 1'b0, wa, 2'b11, 16'h0000, rd, lat);
			check_word("bank spread data", exp_mem[wa], rd);
		end
		pre_cnt = 0;
		foreach (log_cmd[i])
			if (log_cmd[i] == CMD_PRE || log_cmd[i] == CMD_ACT)
				pre_cnt++;
		check_count("bank spread precharge or activate", 0, pre_cnt);
	endtask

	initial begin
		rst_n = 1'b0;
		csr_a = '0;
		csr_we = 1'b0;
		csr_di = '0;
		fml_adr = '0;
		fml_stb = 1'b0;
		fml_we = 1'b0;
		fml_sel = 2'b00;
		fml_di = '0;
		repeat (3) @(negedge sys_clk);
		rst_n = 1'b1;
		test_csr_regs();
		test_bypass_init();
		csr_write(3'd0, 16'h0006);		// soft reset with the scheduler on the pins.
		csr_write(3'd0, 16'h0004);		// controller takes the pins, cke stays on.
		test_write_read();
		test_refresh();
		test_row_miss();		// right after refresh, so no refresh lands in the log.
		test_bank_spread();
		$display("errors: value %0d, command %0d, protocol %0d", value_errs, cmd_errs, proto_errs);
		if (value_errs + cmd_errs + proto_errs == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* sdram_ctl.f */
common/sdram_pkg.sv
common/sdram_cmd_if.sv
common/sdram_sched_if.sv
design/sdram_csr.sv
mgmt/sdram_sched.sv
design/sdram_busif.sv
design/sdram_datactl.sv
design/sdram_dqio.sv
design/sdram_ctl.sv
tests/sdram_ctl_checker.sv
tests/sdram_ctl_tb.sv
